/* hdl/cachePkg.sv */
package cachePkg;

  // Fixed widths shared by every block
  localparam int addrW      = 32;
  localparam int wordW      = 32;
  localparam int blockWords = 4;
  localparam int blockW     = wordW * blockWords;
  localparam int maskW      = wordW / 8;

  // Byte offset inside a block: 2 bits of byte, 2 bits of word
  localparam int offsetW    = 4;

  typedef logic [addrW-1:0]  addrT;   // Byte address
  typedef logic [wordW-1:0]  wordT;   // One data word
  typedef logic [blockW-1:0] blockT;  // Word 0 in the low bits
  typedef logic [maskW-1:0]  maskT;   // One enable per byte

  // Access stage FSM
  // A hit goes idle -> finish -> respond
  // A miss may pass through the writeback pair, then the refill pair
  typedef enum logic [2:0] {
    idle,        // Waiting for a looked-up request
    respond,     // cpuAck high until cpuReq drops
    writeBack,   // memReq high with the dirty victim
    waitWbDrop,  // Waiting for memAck to fall after writeback
    refill,      // memReq high for the missing block
    waitRfDrop,  // Waiting for memAck to fall after refill
    finish       // Merge the write or pick the read word
  } accessStateT;

endpackage

/* hdl/wayBus.sv */
`timescale 1ns/100ps

interface wayBus import cachePkg::*; #(
  parameter int numSets = 64
) ();

  localparam int idxW = $clog2(numSets);
  localparam int tagW = addrW - offsetW - idxW;

  logic [idxW-1:0] index;

  // Combinational read at index
  logic [tagW-1:0] rTag;
  logic            rValid;
  logic            rDirty;
  blockT           rData;

  // Write port, taken at the rising edge
  logic            wEn;
  logic            wFill;   // Whole block plus tag, valid, dirty
  logic [tagW-1:0] wTag;
  logic [1:0]      wWord;   // Word picked for a masked write
  blockT           wData;
  maskT            wMask;
  logic            wDirty;  // Dirty bit given on a fill

  modport way    (input index, wEn, wFill, wTag, wWord, wData, wMask, wDirty,
                  output rTag, rValid, rDirty, rData);
  modport lookup (output index, input rTag, rValid, rDirty, rData);
  modport access (output wEn, wFill, wTag, wWord, wData, wMask, wDirty,
                  input rData);

endinterface

/* hdl/cacheWay.sv */
`timescale 1ns/100ps

module cacheWay import cachePkg::*; #(
  parameter int numSets = 64
) (
  input logic clk,
  input logic reset,
  wayBus.way  wb
);

  localparam int idxW = $clog2(numSets);
  localparam int tagW = addrW - offsetW - idxW;

  logic [tagW-1:0]    tags [numSets];
  logic [numSets-1:0] valid;
  logic [numSets-1:0] dirty;

  // Four word memories, one per word of the block
  wordT dataMem [blockWords][numSets];

  logic [idxW-1:0] idx;

  assign idx = wb.index;

  // Reads
  assign wb.rTag   = tags[idx];
  assign wb.rValid = valid[idx];
  assign wb.rDirty = dirty[idx];

  always_comb begin
    for (int w = 0; w < blockWords; w++) begin
      wb.rData[w*wordW +: wordW] = dataMem[w][idx];
    end
  end

  // Line state
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      valid <= '0;
      dirty <= '0;
    end else if (wb.wEn) begin
      if (wb.wFill) begin
        valid[idx] <= 1'b1;
        dirty[idx] <= wb.wDirty;
      end else begin
        dirty[idx] <= 1'b1;  // Any word write dirties the line
      end
    end
  end

  // Tag only changes on a fill
  always_ff @(posedge clk) begin
    if (wb.wEn && wb.wFill) begin
      tags[idx] <= wb.wTag;
    end
  end

  // Byte-masked word write, or all bytes of all words on a fill
  always_ff @(posedge clk) begin
    if (wb.wEn) begin
      for (int w = 0; w < blockWords; w++) begin
        for (int b = 0; b < maskW; b++) begin
          if (wb.wFill || (wb.wWord == 2'(w) && wb.wMask[b])) begin
            dataMem[w][idx][b*8 +: 8] <= wb.wData[w*wordW + b*8 +: 8];
          end
        end
      end
    end
  end

endmodule

/* hdl/cacheLookup.sv */
`timescale 1ns/100ps

module cacheLookup import cachePkg::*; #(
  parameter int numSets = 64
) (
  input  logic  clk,
  input  logic  reset,
  input  logic  cpuReq,
  input  logic  cpuWe,
  input  addrT  cpuAddr,
  input  wordT  cpuWData,
  input  maskT  cpuMask,
  input  logic  lkDone,
  wayBus.lookup way0,
  wayBus.lookup way1,
  output logic  lkValid,
  output logic  lkWe,
  output addrT  lkAddr,
  output wordT  lkWData,
  output maskT  lkMask,
  output logic  hit,
  output logic  hitWay,
  output logic  victimWay,
  output logic  victimDirty,
  output logic [addrW-offsetW-$clog2(numSets)-1:0] victimTag,
  output blockT victimData
);

  localparam int idxW = $clog2(numSets);
  localparam int tagW = addrW - offsetW - idxW;

  logic [numSets-1:0] lru;  // Points at the least recently used way
  logic [idxW-1:0]    setIdx;
  logic [tagW-1:0]    reqTag;
  logic               hit0;
  logic               hit1;

  assign setIdx = lkAddr[offsetW +: idxW];
  assign reqTag = lkAddr[addrW-1 -: tagW];

  assign way0.index = setIdx;
  assign way1.index = setIdx;

  // Tag compare
  assign hit0   = way0.rValid && (way0.rTag == reqTag);
  assign hit1   = way1.rValid && (way1.rTag == reqTag);
  assign hit    = hit0 || hit1;
  assign hitWay = hit1;

  // Victim choice, invalid way first
  always_comb begin
    if (!way0.rValid) begin
      victimWay = 1'b0;
    end else if (!way1.rValid) begin
      victimWay = 1'b1;
    end else begin
      victimWay = lru[setIdx];
    end
  end

  assign victimDirty = victimWay ? (way1.rValid && way1.rDirty)
                                 : (way0.rValid && way0.rDirty);
  assign victimTag   = victimWay ? way1.rTag : way0.rTag;
  assign victimData  = victimWay ? way1.rData : way0.rData;

  // Request register holds until the access stage is done
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      lkValid <= 1'b0;
    end else if (lkDone) begin
      lkValid <= 1'b0;
    end else if (!lkValid && cpuReq) begin
      lkValid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!lkValid && cpuReq) begin
      lkWe    <= cpuWe;
      lkAddr  <= cpuAddr;
      lkWData <= cpuWData;
      lkMask  <= cpuMask;
    end
  end

  // The line always hits by the time lkDone comes, even after a miss
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      lru <= '0;
    end else if (lkDone) begin
      lru[setIdx] <= ~hitWay;
    end
  end

endmodule

/* hdl/cacheAccess.sv */
`timescale 1ns/100ps

module cacheAccess import cachePkg::*; #(
  parameter int numSets = 64
) (
  input  logic  clk,
  input  logic  reset,
  input  logic  lkValid,
  input  logic  lkWe,
  input  addrT  lkAddr,
  input  wordT  lkWData,
  input  maskT  lkMask,
  input  logic  hit,
  input  logic  hitWay,
  input  logic  victimWay,
  input  logic  victimDirty,
  input  logic [addrW-offsetW-$clog2(numSets)-1:0] victimTag,
  input  blockT victimData,
  output logic  lkDone,
  wayBus.access way0,
  wayBus.access way1,
  input  logic  cpuReq,
  output logic  cpuAck,
  output wordT  cpuRData,
  output logic  memReq,
  input  logic  memAck,
  output logic  memWe,
  output addrT  memAddr,
  output blockT memWData,
  input  blockT memRData
);

  localparam int idxW = $clog2(numSets);
  localparam int tagW = addrW - offsetW - idxW;

  accessStateT state;
  logic        curWay;  // Way being served, kept across the fill
  logic        fillEn;
  logic        wordEn;
  addrT        wbAddr;
  addrT        fillAddr;
  blockT       wayData;
  wordT        readWord;

  assign wbAddr   = {victimTag, lkAddr[offsetW +: idxW], {offsetW{1'b0}}};
  assign fillAddr = {lkAddr[addrW-1:offsetW], {offsetW{1'b0}}};

  assign lkDone = (state == respond) && !cpuReq;

  // Way writes
  assign fillEn = (state == refill) && memAck;
  assign wordEn = (state == finish) && lkWe;

  assign way0.wEn    = (fillEn || wordEn) && !curWay;
  assign way1.wEn    = (fillEn || wordEn) && curWay;
  assign way0.wFill  = fillEn;
  assign way1.wFill  = fillEn;
  assign way0.wTag   = lkAddr[addrW-1 -: tagW];
  assign way1.wTag   = lkAddr[addrW-1 -: tagW];
  assign way0.wWord  = lkAddr[3:2];
  assign way1.wWord  = lkAddr[3:2];
  assign way0.wMask  = lkMask;
  assign way1.wMask  = lkMask;
  assign way0.wDirty = 1'b0;  // Refill lands clean
  assign way1.wDirty = 1'b0;

  // Write word copied to every lane, the way picks its own
  assign way0.wData = fillEn ? memRData : {blockWords{lkWData}};
  assign way1.wData = fillEn ? memRData : {blockWords{lkWData}};

  assign wayData  = curWay ? way1.rData : way0.rData;
  assign readWord = wayData[lkAddr[3:2]*wordW +: wordW];

  // Control
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state  <= idle;
      cpuAck <= 1'b0;
      memReq <= 1'b0;
      memWe  <= 1'b0;
      curWay <= 1'b0;
    end else begin
      case (state)
        idle: if (lkValid) begin
          curWay <= hit ? hitWay : victimWay;
          if (hit) begin
            state <= finish;
          end else if (victimDirty) begin
            state  <= writeBack;
            memReq <= 1'b1;
            memWe  <= 1'b1;
          end else begin
            state  <= refill;
            memReq <= 1'b1;
            memWe  <= 1'b0;
          end
        end
        writeBack: if (memAck) begin
          memReq <= 1'b0;
          state  <= waitWbDrop;
        end
        waitWbDrop: if (!memAck) begin
          memReq <= 1'b1;  // Start the refill
          memWe  <= 1'b0;
          state  <= refill;
        end
        refill: if (memAck) begin
          memReq <= 1'b0;
          state  <= waitRfDrop;
        end
        waitRfDrop: if (!memAck) state <= finish;
        finish: begin
          cpuAck <= 1'b1;
          state  <= respond;
        end
        respond: if (!cpuReq) begin
          cpuAck <= 1'b0;
          state  <= idle;
        end
        default: state <= idle;
      endcase
    end
  end

  // Memory and processor payload
  always_ff @(posedge clk) begin
    if (state == idle && lkValid && !hit) begin
      memAddr  <= victimDirty ? wbAddr : fillAddr;
      memWData <= victimData;
    end else if (state == waitWbDrop && !memAck) begin
      memAddr <= fillAddr;
    end
    if (state == finish) begin
      cpuRData <= readWord;  // Old word on a write
    end
  end

endmodule

/* hdl/cacheTop.sv */
`timescale 1ns/100ps

module cacheTop import cachePkg::*; #(
  parameter int numSets = 64
) (
  input  logic  clk,
  input  logic  reset,
  input  logic  cpuReq,
  input  logic  cpuWe,
  input  addrT  cpuAddr,
  input  wordT  cpuWData,
  input  maskT  cpuMask,
  output logic  cpuAck,
  output wordT  cpuRData,
  output logic  memReq,
  input  logic  memAck,
  output logic  memWe,
  output addrT  memAddr,
  output blockT memWData,
  input  blockT memRData
);

  localparam int tagW = addrW - offsetW - $clog2(numSets);

  // Lookup to access stage
  logic            lkValid;
  logic            lkWe;
  addrT            lkAddr;
  wordT            lkWData;
  maskT            lkMask;
  logic            hit;
  logic            hitWay;
  logic            victimWay;
  logic            victimDirty;
  logic [tagW-1:0] victimTag;
  blockT           victimData;
  logic            lkDone;

  wayBus #(.numSets(numSets)) bus0 ();
  wayBus #(.numSets(numSets)) bus1 ();

  cacheWay #(.numSets(numSets)) u_way0 (.clk, .reset, .wb(bus0));
  cacheWay #(.numSets(numSets)) u_way1 (.clk, .reset, .wb(bus1));

  cacheLookup #(.numSets(numSets)) u_lookup (
    .clk, .reset,
    .cpuReq, .cpuWe, .cpuAddr, .cpuWData, .cpuMask,
    .lkDone,
    .way0(bus0), .way1(bus1),
    .lkValid, .lkWe, .lkAddr, .lkWData, .lkMask,
    .hit, .hitWay, .victimWay, .victimDirty, .victimTag, .victimData
  );

  cacheAccess #(.numSets(numSets)) u_access (
    .clk, .reset,
    .lkValid, .lkWe, .lkAddr, .lkWData, .lkMask,
    .hit, .hitWay, .victimWay, .victimDirty, .victimTag, .victimData,
    .lkDone,
    .way0(bus0), .way1(bus1),
    .cpuReq, .cpuAck, .cpuRData,
    .memReq, .memAck, .memWe, .memAddr, .memWData, .memRData
  );

endmodule

/* tests/cacheAssertions.sv */
`timescale 1ns/100ps

module cacheAssertions import cachePkg::*; (
  input logic clk,
  input logic reset,
  input logic cpuReq,
  input logic cpuAck,
  input logic memReq,
  input logic memAck,
  input addrT memAddr
);

  // Request and address held until memory answers
  property memReqHeld;
    @(posedge clk) disable iff (reset)
      (memReq && !memAck) |=> (memReq && $stable(memAddr));
  endproperty

  property cpuAckHeld;
    @(posedge clk) disable iff (reset)
      (cpuAck && cpuReq) |=> cpuAck;  // Only a dropped cpuReq releases cpuAck
  endproperty

  // memAck as seen at the edge that raised memReq
  property memReqRiseClean;
    @(posedge clk) disable iff (reset)
      $rose(memReq) |-> !$past(memAck);
  endproperty

  assert property (memReqHeld) else $error("memReq or memAddr changed before memAck");
  assert property (cpuAckHeld) else $error("cpuAck fell while cpuReq was high");
  assert property (memReqRiseClean) else $error("memReq rose while memAck was high");

endmodule

bind cacheTop cacheAssertions u_assertions (.*);

/* tests/cacheTb.sv */
`timescale 1ns/100ps

module cacheTb import cachePkg::*; ();

  localparam int clkPeriod  = 8;
  localparam int numRows    = 21;
  localparam int hitLatency = 2;     // Sampling edge to cpuAck
  localparam int memWords   = 4096;  // 16 KB behind the cache
  localparam wordT fillKey  = 32'h5A3C_96E1;

  typedef struct packed {
    logic       we;
    addrT       addr;
    wordT       data;
    maskT       mask;
    logic [1:0] expMem;  // 0 hit, 1 refill, 2 writeback then refill
    addrT       wbAddr;  // Evicted block when expMem is 2
  } rowT;

  logic  clk;
  logic  reset;
  logic  cpuReq;
  logic  cpuWe;
  addrT  cpuAddr;
  wordT  cpuWData;
  maskT  cpuMask;
  logic  cpuAck;
  wordT  cpuRData;
  logic  memReq;
  logic  memAck;
  logic  memWe;
  addrT  memAddr;
  blockT memWData;
  blockT memRData;

  rowT  tbl [numRows];
  wordT memArray [memWords];
  wordT shadow [memWords];
  logic memLogWe [$];   // Memory accesses seen during one row
  addrT memLogAddr [$];
  int   errorCount = 0;

  cacheTop #(.numSets(64)) u_dut (.*);

  always #(clkPeriod/2) clk = ~clk;

  task automatic flagError(input string msg);
    errorCount++;
    $display("** Error at %0t: %s", $time, msg);
  endtask

  function automatic wordT mergeBytes(input wordT old, input wordT data, input maskT mask);
    wordT res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (mask[b]) res[b*8 +: 8] = data[b*8 +: 8];
    end
    return res;
  endfunction

  function automatic blockT shadowBlock(input addrT a);
    blockT blk;
    for (int w = 0; w < blockWords; w++) begin
      blk[w*wordW +: wordW] = shadow[{a[13:4], 2'(w)}];
    end
    return blk;
  endfunction

  // Sets 0, 4, 8 and 16 see the conflicts
  task automatic loadTable();
    tbl[0]  = '{1'b0, 32'h0000, 32'h0, 4'h0, 2'd1, 32'h0};
    tbl[1]  = '{1'b1, 32'h0004, 32'h1122_3344, 4'b0101, 2'd0, 32'h0};
    tbl[2]  = '{1'b0, 32'h0004, 32'h0, 4'h0, 2'd0, 32'h0};
    tbl[3]  = '{1'b1, 32'h000C, 32'hDEAD_BEEF, 4'b1111, 2'd0, 32'h0};
    tbl[4]  = '{1'b0, 32'h000C, 32'h0, 4'h0, 2'd0, 32'h0};
    tbl[5]  = '{1'b1, 32'h0104, 32'hCAFE_F00D, 4'b1000, 2'd1, 32'h0};  // Write-allocate
    tbl[6]  = '{1'b0, 32'h0104, 32'h0, 4'h0, 2'd0, 32'h0};
    tbl[7]  = '{1'b0, 32'h0040, 32'h0, 4'h0, 2'd1, 32'h0};  // A
    tbl[8]  = '{1'b0, 32'h0440, 32'h0, 4'h0, 2'd1, 32'h0};  // B
    tbl[9]  = '{1'b0, 32'h0040, 32'h0, 4'h0, 2'd0, 32'h0};
    tbl[10] = '{1'b0, 32'h0840, 32'h0, 4'h0, 2'd1, 32'h0};  // C evicts B
    tbl[11] = '{1'b0, 32'h0040, 32'h0, 4'h0, 2'd0, 32'h0};
    tbl[12] = '{1'b0, 32'h0440, 32'h0, 4'h0, 2'd1, 32'h0};
    tbl[13] = '{1'b1, 32'h0080, 32'h0102_0304, 4'b1111, 2'd1, 32'h0};
    tbl[14] = '{1'b1, 32'h0484, 32'h5566_7788, 4'b0011, 2'd1, 32'h0};
    tbl[15] = '{1'b0, 32'h0888, 32'h0, 4'h0, 2'd2, 32'h0080};
    tbl[16] = '{1'b0, 32'h1000, 32'h0, 4'h0, 2'd1, 32'h0};  // Flush starts here
    tbl[17] = '{1'b0, 32'h1400, 32'h0, 4'h0, 2'd2, 32'h0000};
    tbl[18] = '{1'b0, 32'h1100, 32'h0, 4'h0, 2'd1, 32'h0};
    tbl[19] = '{1'b0, 32'h1500, 32'h0, 4'h0, 2'd2, 32'h0100};
    tbl[20] = '{1'b0, 32'h1080, 32'h0, 4'h0, 2'd2, 32'h0480};
  endtask

  task automatic runRow(input int r);
    int   word;
    int   waitCycles;
    addrT blockAddr;
    word      = int'(tbl[r].addr[13:2]);
    blockAddr = {tbl[r].addr[31:4], 4'h0};
    memLogWe.delete();
    memLogAddr.delete();
    cpuWe    = tbl[r].we;
    cpuAddr  = tbl[r].addr;
    cpuWData = tbl[r].data;
    cpuMask  = tbl[r].mask;
    cpuReq   = 1'b1;
    waitCycles = 0;
    do begin
      @(negedge clk);
      waitCycles++;
    end while (!cpuAck);
    if (!tbl[r].we && cpuRData != shadow[word])
      flagError($sformatf("row %0d read %h, expected %h", r, cpuRData, shadow[word]));
    if (tbl[r].we) shadow[word] = mergeBytes(shadow[word], tbl[r].data, tbl[r].mask);
    if (tbl[r].expMem == 2'd0 && waitCycles - 1 != hitLatency)
      flagError($sformatf("row %0d hit took %0d cycles", r, waitCycles - 1));
    repeat (r % 3) @(negedge clk);  // Processor keeps its request up a while
    if (!cpuAck)
      flagError($sformatf("row %0d cpuAck dropped while cpuReq was high", r));
    cpuReq = 1'b0;
    do @(negedge clk); while (cpuAck);
    if (memLogWe.size() != int'(tbl[r].expMem)) begin
      flagError($sformatf("row %0d saw %0d memory accesses, expected %0d",
                          r, memLogWe.size(), tbl[r].expMem));
    end else if (tbl[r].expMem == 2'd2) begin
      if (!memLogWe[0] || memLogAddr[0] != tbl[r].wbAddr)
        flagError($sformatf("row %0d writeback at %h, expected %h",
                            r, memLogAddr[0], tbl[r].wbAddr));
      if (memLogWe[1] || memLogAddr[1] != blockAddr)
        flagError($sformatf("row %0d refill at %h, expected %h", r, memLogAddr[1], blockAddr));
    end else if (tbl[r].expMem == 2'd1) begin
      if (memLogWe[0] || memLogAddr[0] != blockAddr)
        flagError($sformatf("row %0d refill at %h, expected %h", r, memLogAddr[0], blockAddr));
    end
  endtask

  // Four-phase memory responder
  initial begin : memModel
    int delay;
    int base;
    void'($urandom(32'h6292));
    memAck   = 1'b0;
    memRData = '0;
    forever begin
      @(negedge clk);
      if (memReq) begin
        delay = 1 + int'($urandom % 4);
        repeat (delay) @(negedge clk);
        base = int'(memAddr[13:4]) * blockWords;
        if (memAddr[3:0] != 4'h0) flagError($sformatf("memAddr %h not block aligned", memAddr));
        if (memWe) begin
          if (memWData != shadowBlock(memAddr))
            flagError($sformatf("writeback to %h carries %h, expected %h",
                                memAddr, memWData, shadowBlock(memAddr)));
          for (int w = 0; w < blockWords; w++) memArray[base + w] = memWData[w*wordW +: wordW];
        end else begin
          for (int w = 0; w < blockWords; w++) memRData[w*wordW +: wordW] = memArray[base + w];
        end
        memLogWe.push_back(memWe);
        memLogAddr.push_back(memAddr);
        memAck = 1'b1;
        do @(negedge clk); while (memReq);
        repeat (int'($urandom % 3)) @(negedge clk);  // Slow memAck release
        memAck = 1'b0;
      end
    end
  end

  initial begin
    #(numRows * 60 * clkPeriod);
    $display("Timeout: the test did not finish in %0d cycles", numRows * 60);
    $display("Errors: %0d", errorCount);
    $display("Done: errors found");
    $finish;
  end

  initial begin
    clk      = 1'b0;
    reset    = 1'b1;
    cpuReq   = 1'b0;
    cpuWe    = 1'b0;
    cpuAddr  = '0;
    cpuWData = '0;
    cpuMask  = '0;
    loadTable();
    for (int i = 0; i < memWords; i++) begin
      memArray[i] = wordT'(i * 4) ^ fillKey;  // Word holds its own address, scrambled
      shadow[i]   = wordT'(i * 4) ^ fillKey;
    end
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    if (cpuAck || memReq) flagError("cpuAck or memReq high after reset");
    for (int r = 0; r < numRows; r++) runRow(r);
    // All dirty lines are flushed by now
    for (int i = 0; i < memWords; i++) begin
      if (memArray[i] != shadow[i])
        flagError($sformatf("memory word %h holds %h, expected %h",
                            i * 4, memArray[i], shadow[i]));
    end
    $display("Errors: %0d", errorCount);
    if (errorCount == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

/* files.f */
hdl/cachePkg.sv
hdl/wayBus.sv
hdl/cacheWay.sv
hdl/cacheLookup.sv
hdl/cacheAccess.sv
hdl/cacheTop.sv
tests/cacheAssertions.sv
tests/cacheTb.sv
